// File: isq_defs.svh
////////////////////////////////////////////////////////////
// issue queue sizing
// depth, instruction word width and register index width
// shared by the packages and every queue block
////////////////////////////////////////////////////////////
`ifndef ISQ_DEFS_SVH
`define ISQ_DEFS_SVH

// number of queue lines
`define ISQ_DEPTH 8

// decoded instruction word, both formats
`define ISQ_INST_WIDTH 56

// architectural register index, 32 registers
`define ISQ_REG_IDX_W 5

// derived sizes
`define ISQ_NUM_REGS (1 << `ISQ_REG_IDX_W)
`define ISQ_LIN_IDX_W ($clog2(`ISQ_DEPTH))

`endif

// File: isq_inst_pkg.sv
////////////////////////////////////////////////////////////
// instruction word types for the issue queue
// alu and load formats share one word, told apart by fmt
// also holds the per-line word kept in each queue line
////////////////////////////////////////////////////////////
`include "isq_defs.svh"

package isq_inst_pkg;

   // fmt bit values, same bit position in both formats
   localparam logic FMT_ALU = 1'b0;
   localparam logic FMT_LD  = 1'b1;

   // field widths left over after the fixed fields
   localparam int ALU_IMM_W = `ISQ_INST_WIDTH - 8 - 3 * `ISQ_REG_IDX_W;
   localparam int LD_OFS_W  = `ISQ_INST_WIDTH - 8 - 2 * `ISQ_REG_IDX_W;

   typedef logic [`ISQ_REG_IDX_W-1:0] reg_idx_t;

   // alu form, two register sources
   typedef struct packed {
      logic                 fmt;
      logic [6:0]           opcode;
      reg_idx_t             dst;
      reg_idx_t             src1;
      reg_idx_t             src2;
      logic [ALU_IMM_W-1:0] imm;
   } alu_fmt_t;

   // load form, base only
   // offset covers the bits where alu src2 would sit
   typedef struct packed {
      logic                fmt;
      logic [6:0]          opcode;
      reg_idx_t            dst;
      reg_idx_t            base;
      logic [LD_OFS_W-1:0] offset;
   } ld_fmt_t;

   typedef union packed {
      alu_fmt_t alu;
      ld_fmt_t  ld;
   } inst_u;

   // one queue line, msb first: brn_wat, wat, inst
   typedef struct packed {
      logic  brn_wat;
      logic  wat;
      inst_u inst;
   } isq_lin_t;

endpackage

// File: isq_sched_pkg.sv
////////////////////////////////////////////////////////////
// scheduler side payloads of the issue queue
// dispatch, issue, writeback and branch resolve
////////////////////////////////////////////////////////////
`include "isq_defs.svh"

package isq_sched_pkg;

   typedef logic [`ISQ_LIN_IDX_W-1:0] lin_idx_t;

   // dispatch payload
   // spec marks an instruction behind the open branch
   typedef struct packed {
      isq_inst_pkg::inst_u inst;
      logic                spec;
   } disp_t;

   // issue payload, line index for debug and tracking
   typedef struct packed {
      isq_inst_pkg::inst_u inst;
      lin_idx_t            line;
   } iss_t;

   // writeback broadcast, one cycle
   typedef struct packed {
      logic                   vld;
      isq_inst_pkg::reg_idx_t tag;
   } wb_t;

   // branch resolve broadcast, one cycle
   typedef struct packed {
      logic vld;
      logic mispred;
   } brn_t;

endpackage

// File: isq_lin.sv
////////////////////////////////////////////////////////////
// single issue queue line
// holds the instruction, wait bit and branch-wait bit
// each group clears first, loads second
////////////////////////////////////////////////////////////
module isq_lin (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   en,
   input  logic                   clr_wat,
   input  logic                   fls_inst,
   input  logic                   clr_inst_brn_wat,
   input  isq_inst_pkg::isq_lin_t isq_lin_in,
   output isq_inst_pkg::isq_lin_t isq_lin_out
);

   logic                wat;
   logic                brn_wat;
   isq_inst_pkg::inst_u inst;

   ////////////////////////////////////////////////////////////
   // wait bit
   ////////////////////////////////////////////////////////////
   // 1 while some source is still pending
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         wat <= 1'b0;
      else if (clr_wat)
         wat <= 1'b0;
      else if (en)
         wat <= isq_lin_in.wat;
   end

   ////////////////////////////////////////////////////////////
   // branch-wait bit
   ////////////////////////////////////////////////////////////
   // 1 means behind an unresolved branch
   // cleared on a correct resolve
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         brn_wat <= 1'b0;
      else if (clr_inst_brn_wat)
         brn_wat <= 1'b0;
      else if (en)
         brn_wat <= isq_lin_in.brn_wat;
   end

   ////////////////////////////////////////////////////////////
   // instruction flops
   ////////////////////////////////////////////////////////////
   // flush zeroes the word only, status bits untouched
   always_ff @(posedge clk)
   begin
      if (fls_inst)
         inst <= '0;
      else if (en)
         inst <= isq_lin_in.inst;
   end

   // same bit order as the line input
   assign isq_lin_out.brn_wat = brn_wat;
   assign isq_lin_out.wat     = wat;
   assign isq_lin_out.inst    = inst;

endmodule

// File: isq_scoreboard.sv
////////////////////////////////////////////////////////////
// register scoreboard
// one pending bit per architectural register
// set at dispatch of a producer, cleared at writeback
////////////////////////////////////////////////////////////
`include "isq_defs.svh"

module isq_scoreboard (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      set_en,
   input  logic [`ISQ_REG_IDX_W-1:0] set_tag,
   input  isq_sched_pkg::wb_t        wb,
   output logic [`ISQ_NUM_REGS-1:0]  pending
);

   logic [`ISQ_NUM_REGS-1:0] pend_q;
   logic [`ISQ_NUM_REGS-1:0] set_vec;
   logic [`ISQ_NUM_REGS-1:0] clr_vec;

   ////////////////////////////////////////////////////////////
   // decode set and clear
   ////////////////////////////////////////////////////////////
   always_comb
   begin
      set_vec = '0;
      clr_vec = '0;
      // destination of the instruction being dispatched
      if (set_en)
      begin
         set_vec[set_tag] = 1'b1;
      end
      // broadcast writeback
      if (wb.vld)
      begin
         clr_vec[wb.tag] = 1'b1;
      end
      // r0 reads as zero, never pending
      set_vec[0] = 1'b0;
   end

   ////////////////////////////////////////////////////////////
   // pending state
   ////////////////////////////////////////////////////////////
   // writeback bypass
   // a tag broadcast this cycle already reads as ready,
   // so a dispatch in the same cycle sees it clear
   assign pending = pend_q & ~clr_vec;

   // set after clear, so a new producer wins over an old writeback
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         pend_q <= '0;
      else
         pend_q <= pending | set_vec;
   end

   // note
   // a producer flushed on mispredict keeps its bit
   // until a later writeback of that tag

endmodule

// File: isq_ctl.sv
////////////////////////////////////////////////////////////
// issue queue control
// line valid vector, allocation, wakeup, issue select,
// mispredict flush and correct-resolve handling
////////////////////////////////////////////////////////////
`include "isq_defs.svh"

module isq_ctl (
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic                      disp_valid,
   input  isq_sched_pkg::disp_t      disp,
   output logic                      disp_ready,
   output logic                      iss_valid,
   output isq_sched_pkg::iss_t       iss,
   input  logic                      iss_ready,
   input  isq_sched_pkg::wb_t        wb,
   input  isq_sched_pkg::brn_t       brn,
   input  logic [`ISQ_NUM_REGS-1:0]  pending,
   input  isq_inst_pkg::isq_lin_t    lin_out [`ISQ_DEPTH],
   output logic [`ISQ_DEPTH-1:0]     en,
   output logic [`ISQ_DEPTH-1:0]     clr_wat,
   output logic [`ISQ_DEPTH-1:0]     clr_val,
   output logic [`ISQ_DEPTH-1:0]     fls_inst,
   output logic [`ISQ_DEPTH-1:0]     clr_inst_brn_wat,
   output isq_inst_pkg::isq_lin_t    lin_in,
   output logic                      sb_set_en,
   output logic [`ISQ_REG_IDX_W-1:0] sb_set_tag
);

   logic [`ISQ_DEPTH-1:0]   val_q;
   logic [`ISQ_DEPTH-1:0]   rdy_vec;
   isq_sched_pkg::lin_idx_t alloc_idx;
   isq_sched_pkg::lin_idx_t pick_idx;
   isq_sched_pkg::lin_idx_t sel_idx;
   isq_sched_pkg::lin_idx_t lock_idx;
   logic                    lock_q;
   logic                    disp_fire;
   logic                    disp_kill;
   logic                    iss_fire;
   logic                    mispred;
   logic                    resolve;

   // any source of this word still pending
   // load reads base only, the src2 bits are offset there
   function automatic logic src_busy(isq_inst_pkg::inst_u inst,
                                     logic [`ISQ_NUM_REGS-1:0] pend);
      if (inst.ld.fmt == isq_inst_pkg::FMT_LD)
         return pend[inst.ld.base];
      return pend[inst.alu.src1] | pend[inst.alu.src2];
   endfunction

   // word reads the broadcast register
   function automatic logic src_hit(isq_inst_pkg::inst_u inst,
                                    isq_inst_pkg::reg_idx_t tag);
      if (inst.ld.fmt == isq_inst_pkg::FMT_LD)
         return inst.ld.base == tag;
      return (inst.alu.src1 == tag) || (inst.alu.src2 == tag);
   endfunction

   assign mispred = brn.vld & brn.mispred;
   assign resolve = brn.vld & ~brn.mispred;

   ////////////////////////////////////////////////////////////
   // dispatch
   ////////////////////////////////////////////////////////////
   // lowest free line
   always_comb
   begin
      alloc_idx = '0;
      for (int i = `ISQ_DEPTH - 1; i >= 0; i--)
      begin
         if (!val_q[i])
            alloc_idx = isq_sched_pkg::lin_idx_t'(i);
      end
   end

   assign disp_ready = ~&val_q;
   assign disp_fire  = disp_valid & disp_ready;
   // spec word racing a mispredict is accepted but dropped
   assign disp_kill  = mispred & disp.spec;

   // wat sees the bypassed pending vector
   assign lin_in.inst    = disp.inst;
   assign lin_in.wat     = src_busy(disp.inst, pending);
   assign lin_in.brn_wat = disp.spec & ~resolve;

   // dst sits at the same bits in both formats
   assign sb_set_en  = disp_fire & ~disp_kill;
   assign sb_set_tag = disp.inst.alu.dst;

   ////////////////////////////////////////////////////////////
   // per-line wakeup, flush, resolve
   ////////////////////////////////////////////////////////////
   // a waiting line only wakes on a writeback of one of its own
   // sources, and only once nothing it reads is pending
   always_comb
   begin
      for (int i = 0; i < `ISQ_DEPTH; i++)
      begin
         en[i] = sb_set_en && (alloc_idx == isq_sched_pkg::lin_idx_t'(i));
         clr_wat[i] = val_q[i] & lin_out[i].wat & wb.vld &
                      src_hit(lin_out[i].inst, wb.tag) &
                      ~src_busy(lin_out[i].inst, pending);
         fls_inst[i] = mispred & val_q[i] & lin_out[i].brn_wat;
         clr_inst_brn_wat[i] = resolve;
         rdy_vec[i] = val_q[i] & ~lin_out[i].wat;
      end
   end

   ////////////////////////////////////////////////////////////
   // issue select
   ////////////////////////////////////////////////////////////
   // plain priority encoder, lowest ready line
   always_comb
   begin
      pick_idx = '0;
      for (int i = `ISQ_DEPTH - 1; i >= 0; i--)
      begin
         if (rdy_vec[i])
            pick_idx = isq_sched_pkg::lin_idx_t'(i);
      end
   end

   // a stalled issue holds its line so a lower line
   // waking up cannot swap the payload under the consumer
   assign sel_idx   = lock_q ? lock_idx : pick_idx;
   assign iss_valid = lock_q | (|rdy_vec);
   assign iss_fire  = iss_valid & iss_ready;
   assign iss.inst  = lin_out[sel_idx].inst;
   assign iss.line  = sel_idx;

   // lines leave at issue or at flush
   always_comb
   begin
      for (int i = 0; i < `ISQ_DEPTH; i++)
      begin
         clr_val[i] = fls_inst[i] |
                      (iss_fire && (sel_idx == isq_sched_pkg::lin_idx_t'(i)));
      end
   end

   ////////////////////////////////////////////////////////////
   // state
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         val_q <= '0;
      else
         val_q <= (val_q & ~clr_val) | en;
   end

   // mispredict cancels a held spec issue
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         lock_q   <= 1'b0;
         lock_idx <= '0;
      end
      else
      begin
         lock_q   <= iss_valid & ~iss_ready & ~fls_inst[sel_idx];
         lock_idx <= sel_idx;
      end
   end

endmodule

// File: isq_top.sv
////////////////////////////////////////////////////////////
// issue queue top
// queue lines, register scoreboard and control block
////////////////////////////////////////////////////////////
`include "isq_defs.svh"

module isq_top (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 disp_valid,
   input  isq_sched_pkg::disp_t disp,
   output logic                 disp_ready,
   output logic                 iss_valid,
   output isq_sched_pkg::iss_t  iss,
   input  logic                 iss_ready,
   input  isq_sched_pkg::wb_t   wb,
   input  isq_sched_pkg::brn_t  brn
);

   logic [`ISQ_DEPTH-1:0]     lin_en;
   logic [`ISQ_DEPTH-1:0]     lin_clr_wat;
   logic [`ISQ_DEPTH-1:0]     lin_fls_inst;
   logic [`ISQ_DEPTH-1:0]     lin_clr_brn_wat;
   isq_inst_pkg::isq_lin_t    lin_in;
   isq_inst_pkg::isq_lin_t    lin_out [`ISQ_DEPTH];
   logic [`ISQ_NUM_REGS-1:0]  pending;
   logic                      sb_set_en;
   logic [`ISQ_REG_IDX_W-1:0] sb_set_tag;

   ////////////////////////////////////////////////////////////
   // control
   ////////////////////////////////////////////////////////////
   // line valid bits live in the control block,
   // so its free strobe has no load here
   isq_ctl u_ctl (
      .clk              (clk),
      .rst_n            (rst_n),
      .disp_valid       (disp_valid),
      .disp             (disp),
      .disp_ready       (disp_ready),
      .iss_valid        (iss_valid),
      .iss              (iss),
      .iss_ready        (iss_ready),
      .wb               (wb),
      .brn              (brn),
      .pending          (pending),
      .lin_out          (lin_out),
      .en               (lin_en),
      .clr_wat          (lin_clr_wat),
      .clr_val          (),
      .fls_inst         (lin_fls_inst),
      .clr_inst_brn_wat (lin_clr_brn_wat),
      .lin_in           (lin_in),
      .sb_set_en        (sb_set_en),
      .sb_set_tag       (sb_set_tag)
   );

   // pending vector comes back with the writeback applied
   isq_scoreboard u_sb (
      .clk     (clk),
      .rst_n   (rst_n),
      .set_en  (sb_set_en),
      .set_tag (sb_set_tag),
      .wb      (wb),
      .pending (pending)
   );

   ////////////////////////////////////////////////////////////
   // queue lines
   ////////////////////////////////////////////////////////////
   // one shared input word, en picks the line
   for (genvar g = 0; g < `ISQ_DEPTH; g++)
   begin : g_lin
      isq_lin u_lin (
         .clk              (clk),
         .rst_n            (rst_n),
         .en               (lin_en[g]),
         .clr_wat          (lin_clr_wat[g]),
         .fls_inst         (lin_fls_inst[g]),
         .clr_inst_brn_wat (lin_clr_brn_wat[g]),
         .isq_lin_in       (lin_in),
         .isq_lin_out      (lin_out[g])
      );
   end

endmodule

// File: tb_isq.sv
////////////////////////////////////////////////////////////
// issue queue testbench
// table of dispatch, writeback and branch steps per test,
// issue order and payload hold checked under random stalls
////////////////////////////////////////////////////////////
`include "isq_defs.svh"

module tb_isq;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_ROWS   = 6;
   localparam int MAX_STEP   = `ISQ_DEPTH;
   localparam int WAIT_LIMIT = 200;

   logic                 clk;
   logic                 rst_n;
   logic                 disp_valid;
   isq_sched_pkg::disp_t disp;
   logic                 disp_ready;
   logic                 iss_valid;
   isq_sched_pkg::iss_t  iss;
   logic                 iss_ready;
   isq_sched_pkg::wb_t   wb;
   isq_sched_pkg::brn_t  brn;

   ////////////////////////////////////////////////////////////
   // stimulus table with one index per test
   ////////////////////////////////////////////////////////////
   // branch action 0 is none, 1 mispredict and 2 correct resolve
   string                  t_name  [NUM_ROWS];
   int                     t_brn   [NUM_ROWS];
   int                     t_ndisp [NUM_ROWS];
   isq_inst_pkg::inst_u    t_inst  [NUM_ROWS][MAX_STEP];
   logic                   t_spec  [NUM_ROWS][MAX_STEP];
   int                     t_nwb   [NUM_ROWS];
   isq_inst_pkg::reg_idx_t t_wb    [NUM_ROWS][MAX_STEP];
   // expected opcode and the writeback step it issues after
   int                     t_nexp  [NUM_ROWS];
   logic [6:0]             t_exp   [NUM_ROWS][MAX_STEP];
   int                     t_phase [NUM_ROWS][MAX_STEP];
   int                     n_rows;

   int          errors;
   int          tests_run;
   int          issued;
   logic        timed_out;
   logic [31:0] rng;

   isq_top uut (
      .clk        (clk),
      .rst_n      (rst_n),
      .disp_valid (disp_valid),
      .disp       (disp),
      .disp_ready (disp_ready),
      .iss_valid  (iss_valid),
      .iss        (iss),
      .iss_ready  (iss_ready),
      .wb         (wb),
      .brn        (brn)
   );

   // 10 ns clock
   always #5 clk = ~clk;

   function automatic logic [31:0] xorshift32(logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // alu word with fmt 0
   function automatic isq_inst_pkg::inst_u alu_op(logic [6:0] op,
         isq_inst_pkg::reg_idx_t dst, isq_inst_pkg::reg_idx_t s1,
         isq_inst_pkg::reg_idx_t s2);
      isq_inst_pkg::inst_u u;
      u = '0;
      u.alu.fmt    = 1'b0;
      u.alu.opcode = op;
      u.alu.dst    = dst;
      u.alu.src1   = s1;
      u.alu.src2   = s2;
      return u;
   endfunction

   // load word with fmt 1
   // ovl lands in the offset bits where alu src2 would sit
   function automatic isq_inst_pkg::inst_u ld_op(logic [6:0] op,
         isq_inst_pkg::reg_idx_t dst, isq_inst_pkg::reg_idx_t base,
         isq_inst_pkg::reg_idx_t ovl);
      isq_inst_pkg::inst_u u;
      u = '0;
      u.ld.fmt    = 1'b1;
      u.ld.opcode = op;
      u.ld.dst    = dst;
      u.ld.base   = base;
      u.ld.offset[isq_inst_pkg::LD_OFS_W-1 -: `ISQ_REG_IDX_W] = ovl;
      return u;
   endfunction

   task automatic check_eq(string what, logic [63:0] expected, logic [63:0] actual);
      if (expected !== actual)
      begin
         $display("MISMATCH %s expected %0h actual %0h", what, expected, actual);
         errors++;
      end
   endtask

   task automatic finish_run();
      $display("tests run %0d, errors %0d", tests_run, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   endtask

   task automatic report_timeout(string what);
      $display("timeout: %s", what);
      errors++;
      timed_out = 1'b1;
   endtask

   task automatic report_test(string name, int n_err);
      if (n_err == 0)
         $display("test %s passed", name);
      else
         $display("test %s failed with %0d errors", name, n_err);
   endtask

   ////////////////////////////////////////////////////////////
   // table building
   ////////////////////////////////////////////////////////////
   task automatic start_row(string name, int brn_act);
      t_name[n_rows]  = name;
      t_brn[n_rows]   = brn_act;
      t_ndisp[n_rows] = 0;
      t_nwb[n_rows]   = 0;
      t_nexp[n_rows]  = 0;
      n_rows++;
   endtask

   task automatic add_disp(isq_inst_pkg::inst_u inst, logic spec);
      t_inst[n_rows-1][t_ndisp[n_rows-1]] = inst;
      t_spec[n_rows-1][t_ndisp[n_rows-1]] = spec;
      t_ndisp[n_rows-1]++;
   endtask

   task automatic add_wb(isq_inst_pkg::reg_idx_t tag);
      t_wb[n_rows-1][t_nwb[n_rows-1]] = tag;
      t_nwb[n_rows-1]++;
   endtask

   task automatic add_expect(logic [6:0] op, int phase);
      t_exp[n_rows-1][t_nexp[n_rows-1]]   = op;
      t_phase[n_rows-1][t_nexp[n_rows-1]] = phase;
      t_nexp[n_rows-1]++;
   endtask

   task automatic build_table();
      // nothing pending so issue follows dispatch order
      start_row("reset_order", 0);
      add_disp(alu_op(7'd10, 5'd0, 5'd0, 5'd0), 1'b0);
      add_disp(alu_op(7'd11, 5'd0, 5'd1, 5'd2), 1'b0);
      add_disp(ld_op(7'd12, 5'd0, 5'd0, 5'd0), 1'b0);
      add_expect(7'd10, 0);
      add_expect(7'd11, 0);
      add_expect(7'd12, 0);
      // consumer needs both r3 and r4
      start_row("wakeup_alu", 0);
      add_disp(alu_op(7'd20, 5'd3, 5'd0, 5'd0), 1'b0);
      add_disp(alu_op(7'd21, 5'd4, 5'd0, 5'd0), 1'b0);
      add_disp(alu_op(7'd22, 5'd0, 5'd3, 5'd4), 1'b0);
      add_wb(5'd3);
      add_wb(5'd4);
      add_expect(7'd20, 0);
      add_expect(7'd21, 0);
      add_expect(7'd22, 2);
      // load base r6 while r7 sits in the src2 overlap and is ignored
      start_row("wakeup_load", 0);
      add_disp(alu_op(7'd30, 5'd6, 5'd0, 5'd0), 1'b0);
      add_disp(alu_op(7'd31, 5'd7, 5'd0, 5'd0), 1'b0);
      add_disp(ld_op(7'd32, 5'd0, 5'd6, 5'd7), 1'b0);
      add_disp(alu_op(7'd33, 5'd0, 5'd0, 5'd7), 1'b0);
      add_wb(5'd6);
      add_wb(5'd7);
      add_expect(7'd30, 0);
      add_expect(7'd31, 0);
      add_expect(7'd32, 1);
      add_expect(7'd33, 2);
      // one producer plus seven consumers of r9 fill every line
      start_row("full_queue", 0);
      add_disp(alu_op(7'd40, 5'd9, 5'd0, 5'd0), 1'b0);
      for (int i = 0; i < `ISQ_DEPTH - 1; i++)
         add_disp(alu_op(7'd41 + 7'(i), 5'd0, 5'd9, 5'(i)), 1'b0);
      add_wb(5'd9);
      add_expect(7'd40, 0);
      for (int i = 0; i < `ISQ_DEPTH - 1; i++)
         add_expect(7'd41 + 7'(i), 1);
      // spec line 0 is ready and held at the mispredict
      start_row("mispredict", 1);
      add_disp(alu_op(7'd62, 5'd0, 5'd0, 5'd0), 1'b1);
      add_disp(alu_op(7'd60, 5'd10, 5'd0, 5'd0), 1'b0);
      add_disp(alu_op(7'd61, 5'd0, 5'd10, 5'd0), 1'b1);
      add_disp(alu_op(7'd63, 5'd0, 5'd0, 5'd10), 1'b0);
      add_wb(5'd10);
      add_expect(7'd60, 0);
      add_expect(7'd63, 1);
      // spec lines survive a correct resolve
      start_row("correct_resolve", 2);
      add_disp(alu_op(7'd72, 5'd11, 5'd0, 5'd0), 1'b0);
      add_disp(alu_op(7'd70, 5'd0, 5'd0, 5'd0), 1'b1);
      add_disp(ld_op(7'd71, 5'd12, 5'd11, 5'd0), 1'b1);
      add_wb(5'd11);
      add_wb(5'd12);
      add_expect(7'd72, 0);
      add_expect(7'd70, 0);
      add_expect(7'd71, 1);
   endtask

   ////////////////////////////////////////////////////////////
   // stimulus steps
   ////////////////////////////////////////////////////////////
   // iss_ready stays low here so lines fill from index 0
   task automatic dispatch_row(int r);
      int wait_cnt;
      for (int i = 0; i < t_ndisp[r]; i++)
      begin
         @(posedge clk);
         disp_valid <= 1'b1;
         disp.inst  <= t_inst[r][i];
         disp.spec  <= t_spec[r][i];
         @(negedge clk);
         wait_cnt = 0;
         while (!disp_ready && wait_cnt < WAIT_LIMIT)
         begin
            @(negedge clk);
            wait_cnt++;
         end
         if (!disp_ready)
         begin
            report_timeout({t_name[r], " disp_ready never rose"});
            return;
         end
      end
      @(posedge clk);
      disp_valid <= 1'b0;
      @(negedge clk);
      check_eq({t_name[r], " disp_ready after dispatch"},
               64'(t_ndisp[r] < `ISQ_DEPTH), 64'(disp_ready));
   endtask

   task automatic branch_step(int act);
      if (act != 0)
      begin
         @(posedge clk);
         brn.vld     <= 1'b1;
         brn.mispred <= (act == 1);
         @(posedge clk);
         brn <= '0;
      end
   endtask

   task automatic writeback_step(isq_inst_pkg::reg_idx_t tag);
      @(posedge clk);
      wb.vld <= 1'b1;
      wb.tag <= tag;
      @(posedge clk);
      wb <= '0;
   endtask

   task automatic record_issue(int r, int phase);
      logic [6:0] op;
      int         exp_line;
      // opcode sits at the same bits in both formats
      op = iss.inst.alu.opcode;
      if (issued < t_nexp[r])
      begin
         // an empty queue fills from line 0 in dispatch order
         exp_line = 0;
         for (int j = 0; j < t_ndisp[r]; j++)
         begin
            if (t_inst[r][j].alu.opcode == t_exp[r][issued])
               exp_line = j;
         end
         check_eq({t_name[r], " issue opcode"}, 64'(t_exp[r][issued]), 64'(op));
         check_eq({t_name[r], " issue line"}, 64'(exp_line), 64'(iss.line));
         check_eq({t_name[r], " issue step"}, 64'(t_phase[r][issued]), 64'(phase));
      end
      else
      begin
         $display("%s issued opcode %0d beyond the expected list", t_name[r], op);
         errors++;
      end
      issued++;
   endtask

   // issue everything ready under random stalls on iss_ready
   task automatic drain(int r, int phase);
      int                  cyc;
      logic                done;
      logic                got;
      logic                held;
      isq_sched_pkg::iss_t held_iss;
      cyc      = 0;
      done     = 1'b0;
      got      = 1'b0;
      held     = 1'b0;
      held_iss = '0;
      while (!done && cyc < WAIT_LIMIT)
      begin
         @(posedge clk);
         rng = xorshift32(rng);
         iss_ready <= (rng[1:0] != 2'b00);
         @(negedge clk);
         cyc++;
         // stalled payload must hold
         if (held)
         begin
            check_eq({t_name[r], " iss_valid under stall"}, 64'(1'b1), 64'(iss_valid));
            check_eq({t_name[r], " iss under stall"}, 64'(held_iss), 64'(iss));
         end
         if (!iss_valid)
            done = 1'b1;
         else if (iss_ready)
         begin
            record_issue(r, phase);
            got = 1'b1;
         end
         held     = iss_valid & ~iss_ready;
         held_iss = iss;
      end
      if (!done)
      begin
         report_timeout({t_name[r], " iss_valid never dropped"});
         return;
      end
      // a freed line reopens dispatch
      if (got)
         check_eq({t_name[r], " disp_ready after issue"}, 64'(1'b1), 64'(disp_ready));
      @(posedge clk);
      iss_ready <= 1'b0;
   endtask

   task automatic run_row(int r);
      int err_before;
      err_before = errors;
      issued     = 0;
      dispatch_row(r);
      if (!timed_out)
      begin
         branch_step(t_brn[r]);
         drain(r, 0);
      end
      for (int w = 0; w < t_nwb[r] && !timed_out; w++)
      begin
         writeback_step(t_wb[r][w]);
         drain(r, w + 1);
      end
      check_eq({t_name[r], " issue count"}, 64'(t_nexp[r]), 64'(issued));
      report_test(t_name[r], errors - err_before);
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////
   initial
   begin
      clk        = 1'b0;
      rst_n      = 1'b0;
      disp_valid = 1'b0;
      disp       = '0;
      iss_ready  = 1'b0;
      wb         = '0;
      brn        = '0;
      errors     = 0;
      tests_run  = 0;
      issued     = 0;
      timed_out  = 1'b0;
      n_rows     = 0;
      rng        = 32'h886c_d65c;
      build_table();
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_eq("reset iss_valid", 64'(1'b0), 64'(iss_valid));
      check_eq("reset disp_ready", 64'(1'b1), 64'(disp_ready));
      tests_run++;
      report_test("reset_state", errors);
      for (int r = 0; r < n_rows && !timed_out; r++)
      begin
         run_row(r);
         tests_run++;
      end
      finish_run();
   end

endmodule

// File: src.f
+incdir+.
isq_inst_pkg.sv
isq_sched_pkg.sv
isq_lin.sv
isq_scoreboard.sv
isq_ctl.sv
isq_top.sv
tb_isq.sv

// File: run.sh
#!/bin/sh
# build and run the issue queue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_isq -o tb_isq_sim
./obj_dir/tb_isq_sim > sim.log
cat sim.log

if grep -q "^Done: no errors$" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
